// ==== instructionBuffer.f ====
ibuffPkg.sv
ibuffIf.sv
ibuffStorage.sv
ibuffWriteCtrl.sv
ibuffDispatchCtrl.sv
ibuffOccupancy.sv
instructionBuffer.sv
instructionBuffer_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the instruction buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f instructionBuffer.f \
  --top-module instructionBuffer_tb \
  -o simv

# The log decides the result, the simulator status is not used
./obj_dir/simv | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== instructionBuffer_tb.sv ====
`timescale 1ns/1ps

module instructionBuffer_tb;

  localparam int WP    = ibuffPkg::DefaultWritePorts;
  localparam int DL    = ibuffPkg::DefaultDispatchLanes;
  localparam int Depth = ibuffPkg::DefaultDepth;
  localparam logic [ibuffPkg::StatusWidth-1:0] FpOn = 32'(1) << ibuffPkg::StatusFpEnable;
  localparam logic [6:0] OpAlu    = 7'b0110011;
  localparam logic [6:0] OpLoad   = 7'b0000011;
  localparam logic [6:0] OpSystem = 7'b1110011;

  // One write bundle with lane 0 in the low bits
  typedef ibuffPkg::ibuffPacket [WP-1:0] laneBundle;

  // What the buffer should show in one cycle
  typedef struct packed {
    logic                          ready;
    logic                          full;
    logic                          serial;
    ibuffPkg::ibuffPacket [DL-1:0] lanes;
  } refResult;

  logic                             clk;
  logic                             reset;
  logic                             flush;
  logic                             stall;
  logic                             commitCsr;
  logic                             decodeReady;
  ibuffPkg::ibuffPacket             ibPacket [WP];
  logic [ibuffPkg::StatusWidth-1:0] csrStatus;
  logic                             instBufferFull;
  logic                             instBufferReady;
  logic                             stallForCsr;
  ibuffPkg::ibuffPacket             renPacket [DL];

  // Model state of the compare process
  ibuffPkg::ibuffPacket modelQ [$];
  logic                 modelCsr = 1'b0;
  logic                 modelExc = 1'b0;
  logic                 csrSet;
  logic                 excSet;
  refResult             expNow;
  int                   cmpErrs = 0;
  int                   markerSeen = 0;

  // Stimulus side bookkeeping
  int          stimErrs = 0;
  int          errMark = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  logic [31:0] lfsr;
  logic [15:0] tagSeq;

  instructionBuffer #(
    .WritePorts    (WP),
    .DispatchLanes (DL),
    .Depth         (Depth)
  ) UUT (
    .clk               (clk),
    .reset             (reset),
    .flush_i           (flush),
    .stall_i           (stall),
    .commitCsr_i       (commitCsr),
    .decodeReady_i     (decodeReady),
    .ibPacket_i        (ibPacket),
    .csrStatus_i       (csrStatus),
    .instBufferFull_o  (instBufferFull),
    .instBufferReady_o (instBufferReady),
    .stallForCsr_o     (stallForCsr),
    .renPacket_o       (renPacket)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic isFpOp(input logic [6:0] op);
    return (op == ibuffPkg::OpLoadFp) || (op == ibuffPkg::OpStoreFp) ||
           (op == ibuffPkg::OpOpFp);
  endfunction

  // Expected bundle from the model queue, oldest entry first
  function automatic refResult refBundle(input ibuffPkg::ibuffPacket q[$], input int count,
                                         input logic csrSt, input logic excSt,
                                         input logic stallIn,
                                         input logic [ibuffPkg::StatusWidth-1:0] status);
    refResult             e;
    ibuffPkg::ibuffPacket p;
    logic                 prevOk;
    e        = '0;
    e.full   = count > (Depth - WP);
    e.serial = csrSt | excSt;
    e.ready  = (count >= DL) && !stallIn && !e.serial;
    prevOk   = e.ready;
    for (int i = 0; i < DL; i++)
    begin
      p = '0;
      if (i < count)
      begin
        p = q[i];
        // FP work with the unit off traps
        if (!status[ibuffPkg::StatusFpEnable] && isFpOp(p.opcode))
        begin
          p.exception = 1'b1;
          p.cause     = ibuffPkg::CauseFpDisabled;
        end
      end
      p.valid    = prevOk && (i < count);
      // CSR or trap closes the bundle
      prevOk     = p.valid && !p.isCsr && !p.exception;
      e.lanes[i] = p;
    end
    return e;
  endfunction

  task automatic checkVal(input string name, input logic [63:0] got,
                          input logic [63:0] want, inout int errs);
    if (got !== want)
    begin
      $display("** Error %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
      errs++;
    end
  endtask

  task automatic timedOut(input string what);
    $display("Timeout: %s at %0t", what, $time);
    stimErrs++;
  endtask

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
      begin
        lfsr = lfsr ^ 32'h8020_0003;
      end
      r = {r[30:0], b};
    end
    return r;
  endfunction

  // Tag ends in a running number so order is visible in the log
  function automatic ibuffPkg::ibuffPacket makePacket(input logic [6:0] op, input logic csr,
                                                      input logic marker);
    ibuffPkg::ibuffPacket p;
    logic [31:0]          r;
    r        = randBits(9);
    p        = '0;
    p.valid  = 1'b1;
    p.opcode = op;
    p.isCsr  = csr;
    p.tag    = {marker, r[8:0], tagSeq};
    tagSeq   = tagSeq + 16'd1;
    return p;
  endfunction

  function automatic ibuffPkg::ibuffPacket randPacket();
    logic [31:0] r;
    logic [6:0]  op;
    r = randBits(2);
    case (r[1:0])
      2'd0:    op = OpAlu;
      2'd1:    op = OpLoad;
      2'd2:    op = ibuffPkg::OpOpFp;
      default: op = ibuffPkg::OpStoreFp;
    endcase
    return makePacket(op, 1'b0, 1'b0);
  endfunction

  // First n lanes valid
  function automatic laneBundle plainBundle(input int n, input logic marker);
    laneBundle b;
    b = '0;
    for (int i = 0; i < n; i++)
    begin
      b[i] = makePacket(OpAlu, 1'b0, marker);
    end
    return b;
  endfunction

  function automatic int errTotal();
    return cmpErrs + stimErrs;
  endfunction

  // Compare against the model each cycle, then step the model
  always @(negedge clk)
  begin
    if (!reset)
    begin
      expNow = refBundle(modelQ, modelQ.size(), modelCsr, modelExc, stall, csrStatus);
      checkVal("instBufferReady_o", 64'(instBufferReady), 64'(expNow.ready), cmpErrs);
      checkVal("instBufferFull_o", 64'(instBufferFull), 64'(expNow.full), cmpErrs);
      checkVal("stallForCsr_o", 64'(stallForCsr), 64'(expNow.serial), cmpErrs);
      csrSet = 1'b0;
      excSet = 1'b0;
      for (int i = 0; i < DL; i++)
      begin
        checkVal($sformatf("renPacket_o[%0d].valid", i), 64'(renPacket[i].valid),
                 64'(expNow.lanes[i].valid), cmpErrs);
        // Fields of an invalid lane are don't care
        if (expNow.lanes[i].valid)
        begin
          checkVal($sformatf("renPacket_o[%0d]", i), 64'(renPacket[i]),
                   64'(expNow.lanes[i]), cmpErrs);
          csrSet = csrSet | expNow.lanes[i].isCsr;
          excSet = excSet | expNow.lanes[i].exception;
        end
        if (renPacket[i].valid && renPacket[i].tag[25])
        begin
          markerSeen++;
        end
      end
      if (flush)
      begin
        modelQ.delete();
        modelCsr = 1'b0;
        modelExc = 1'b0;
      end
      else
      begin
        for (int i = 0; i < DL; i++)
        begin
          if (expNow.lanes[i].valid)
          begin
            void'(modelQ.pop_front());
          end
        end
        // Whole bundle taken only below the full mark
        if (decodeReady && !expNow.full)
        begin
          for (int i = 0; i < WP; i++)
          begin
            if (ibPacket[i].valid)
            begin
              modelQ.push_back(ibPacket[i]);
            end
          end
        end
        if (commitCsr)
        begin
          modelCsr = 1'b0;
        end
        else if (csrSet)
        begin
          modelCsr = 1'b1;
        end
        if (excSet)
        begin
          modelExc = 1'b1;
        end
      end
    end
  end

  task driveBundle(input laneBundle b, input logic rdy);
    @(posedge clk);
    for (int i = 0; i < WP; i++)
    begin
      ibPacket[i] <= b[i];
    end
    decodeReady <= rdy;
  endtask

  task driveIdle();
    driveBundle('0, 1'b0);
  endtask

  task randomCycle();
    laneBundle   b;
    logic [31:0] r;
    for (int i = 0; i < WP; i++)
    begin
      r    = randBits(1);
      b[i] = r[0] ? randPacket() : '0;
    end
    r = randBits(4);
    driveBundle(b, r[1:0] != 2'd0);
    stall <= (r[3:2] == 2'd0);
  endtask

  // Junk packets ride along with the flush and must be dropped
  task flushPulse(input logic junk);
    driveBundle(junk ? plainBundle(WP, 1'b1) : '0, junk);
    flush     <= 1'b1;
    stall     <= 1'b0;
    commitCsr <= 1'b0;
    driveIdle();
    flush <= 1'b0;
  endtask

  task fillUntilFull();
    int n;
    n = 0;
    do
    begin
      driveBundle(plainBundle(WP, 1'b0), 1'b1);
      @(negedge clk);
      n++;
    end while (!instBufferFull && n < 20);
    if (!instBufferFull)
    begin
      timedOut("instBufferFull_o never rose while filling");
    end
  endtask

  task waitSerial();
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end while (!stallForCsr && n < 20);
    if (!stallForCsr)
    begin
      timedOut("stallForCsr_o never rose");
    end
  endtask

  // Drained means less than a full bundle left
  task waitDrained();
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end while (instBufferReady && n < 100);
    if (instBufferReady)
    begin
      timedOut("buffer never drained");
    end
  endtask

  task pulseCommit();
    @(posedge clk);
    commitCsr <= 1'b1;
    @(posedge clk);
    commitCsr <= 1'b0;
  endtask

  task endTest(input string name);
    int n;
    @(posedge clk);
    n = errTotal() - errMark;
    testsRun++;
    if (n == 0)
    begin
      $display("Test %s: ok", name);
    end
    else
    begin
      $display("Test %s: %0d errors", name, n);
      testsFailed++;
    end
    errMark = errTotal();
  endtask

  initial
  begin
    laneBundle b;
    lfsr        = 32'hd578_361d;
    tagSeq      = '0;
    reset       <= 1'b1;
    flush       <= 1'b0;
    stall       <= 1'b0;
    commitCsr   <= 1'b0;
    decodeReady <= 1'b0;
    csrStatus   <= FpOn;
    for (int i = 0; i < WP; i++)
    begin
      ibPacket[i] <= '0;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // Random traffic wraps the 12 entries many times
    repeat (240) randomCycle();
    driveIdle();
    stall <= 1'b0;
    waitDrained();
    endTest("random order and wrap");

    // Fill under back-pressure, then offer marked packets
    flushPulse(1'b0);
    stall <= 1'b1;
    fillUntilFull();
    repeat (3) driveBundle(plainBundle(WP, 1'b1), 1'b1);
    driveIdle();
    stall <= 1'b0;
    waitDrained();
    @(posedge clk);
    checkVal("markerSeen", 64'(markerSeen), 64'(0), stimErrs);
    endTest("full threshold");

    flushPulse(1'b0);
    driveBundle(plainBundle(3, 1'b0), 1'b1);
    stall <= 1'b1;
    driveIdle();
    repeat (4)
    begin
      @(negedge clk);
      checkVal("instBufferReady_o", 64'(instBufferReady), 64'(0), stimErrs);
      checkVal("renPacket_o[0].valid", 64'(renPacket[0].valid), 64'(0), stimErrs);
    end
    @(posedge clk);
    stall <= 1'b0;
    waitDrained();
    endTest("stall back-pressure");

    // CSR at the head goes out alone
    flushPulse(1'b0);
    b           = plainBundle(3, 1'b0);
    b[0].isCsr  = 1'b1;
    b[0].opcode = OpSystem;
    driveBundle(b, 1'b1);
    driveIdle();
    waitSerial();
    repeat (3)
    begin
      @(negedge clk);
      checkVal("instBufferReady_o", 64'(instBufferReady), 64'(0), stimErrs);
      checkVal("renPacket_o[0].valid", 64'(renPacket[0].valid), 64'(0), stimErrs);
    end
    pulseCommit();
    waitDrained();
    checkVal("stallForCsr_o", 64'(stallForCsr), 64'(0), stimErrs);
    endTest("CSR serialization");

    // With the FP unit off the head packet traps and closes the bundle
    flushPulse(1'b0);
    csrStatus   <= '0;
    b           = plainBundle(3, 1'b0);
    b[0].opcode = ibuffPkg::OpOpFp;
    driveBundle(b, 1'b1);
    driveIdle();
    waitSerial();
    // A CSR commit does not end an exception stall
    pulseCommit();
    repeat (2)
    begin
      @(negedge clk);
      checkVal("stallForCsr_o", 64'(stallForCsr), 64'(1), stimErrs);
      checkVal("instBufferReady_o", 64'(instBufferReady), 64'(0), stimErrs);
    end
    flushPulse(1'b0);
    @(negedge clk);
    checkVal("stallForCsr_o", 64'(stallForCsr), 64'(0), stimErrs);
    @(posedge clk);
    csrStatus   <= FpOn;
    b           = plainBundle(2, 1'b0);
    b[0].opcode = ibuffPkg::OpLoadFp;
    driveBundle(b, 1'b1);
    driveIdle();
    waitDrained();
    endTest("FP disabled trap");

    // Flush out of a full, serialized buffer
    flushPulse(1'b0);
    b           = plainBundle(2, 1'b0);
    b[0].isCsr  = 1'b1;
    b[0].opcode = OpSystem;
    driveBundle(b, 1'b1);
    driveIdle();
    waitSerial();
    fillUntilFull();
    flushPulse(1'b1);
    @(negedge clk);
    checkVal("instBufferFull_o", 64'(instBufferFull), 64'(0), stimErrs);
    checkVal("instBufferReady_o", 64'(instBufferReady), 64'(0), stimErrs);
    checkVal("stallForCsr_o", 64'(stallForCsr), 64'(0), stimErrs);
    driveBundle(plainBundle(WP, 1'b0), 1'b1);
    driveIdle();
    waitDrained();
    @(posedge clk);
    checkVal("markerSeen", 64'(markerSeen), 64'(0), stimErrs);
    endTest("flush");

    $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errTotal());
    if (errTotal() == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== instructionBuffer.sv ====
`timescale 1ns/1ps

module instructionBuffer #(
  parameter int WritePorts    = ibuffPkg::DefaultWritePorts,
  parameter int DispatchLanes = ibuffPkg::DefaultDispatchLanes,
  parameter int Depth         = ibuffPkg::DefaultDepth
) (
  input  logic                             clk,
  input  logic                             reset,
  // Mispredict, empty everything
  input  logic                             flush_i,
  // Back-pressure from rename and dispatch
  input  logic                             stall_i,
  // Serializing CSR has retired
  input  logic                             commitCsr_i,
  input  logic                             decodeReady_i,
  input  ibuffPkg::ibuffPacket             ibPacket_i  [WritePorts],
  input  logic [ibuffPkg::StatusWidth-1:0] csrStatus_i,
  // Tells fetch to hold, no room for another full bundle
  output logic                             instBufferFull_o,
  output logic                             instBufferReady_o,
  output logic                             stallForCsr_o,
  output ibuffPkg::ibuffPacket             renPacket_o [DispatchLanes]
);

  localparam int CntWidth = $clog2(Depth) + 1;

  logic [CntWidth-1:0] instCount;
  logic                bufFull;
  logic                bundleAvail;

  ibuffWrIf #(.Depth(Depth), .WritePorts(WritePorts)) wrBus ();
  ibuffRdIf #(.Depth(Depth), .DispatchLanes(DispatchLanes)) rdBus ();

  // Entry array between the two controllers
  ibuffStorage #(
    .Depth         (Depth),
    .WritePorts    (WritePorts),
    .DispatchLanes (DispatchLanes)
  ) storage (
    .clk (clk),
    .wr  (wrBus.mem),
    .rd  (rdBus.mem)
  );

  // Tail side
  ibuffWriteCtrl #(
    .Depth      (Depth),
    .WritePorts (WritePorts)
  ) writeCtrl (
    .clk           (clk),
    .reset         (reset),
    .flush_i       (flush_i),
    .decodeReady_i (decodeReady_i),
    .bufFull_i     (bufFull),
    .ibPacket_i    (ibPacket_i),
    .wr            (wrBus.ctrl)
  );

  // Head side, bundle shaping and serialization
  ibuffDispatchCtrl #(
    .Depth         (Depth),
    .DispatchLanes (DispatchLanes)
  ) dispatchCtrl (
    .clk               (clk),
    .reset             (reset),
    .flush_i           (flush_i),
    .stall_i           (stall_i),
    .commitCsr_i       (commitCsr_i),
    .csrStatus_i       (csrStatus_i),
    .instCount_i       (instCount),
    .bundleAvail_i     (bundleAvail),
    .instBufferReady_o (instBufferReady_o),
    .stallForCsr_o     (stallForCsr_o),
    .renPacket_o       (renPacket_o),
    .rd                (rdBus.ctrl)
  );

  // Fill level from both sides
  ibuffOccupancy #(
    .Depth         (Depth),
    .WritePorts    (WritePorts),
    .DispatchLanes (DispatchLanes)
  ) occupancy (
    .clk           (clk),
    .reset         (reset),
    .flush_i       (flush_i),
    .wr            (wrBus.count),
    .rd            (rdBus.count),
    .instCount_o   (instCount),
    .bufFull_o     (bufFull),
    .bundleAvail_o (bundleAvail)
  );

  assign instBufferFull_o = bufFull;

endmodule

// ==== ibuffOccupancy.sv ====
`timescale 1ns/1ps

module ibuffOccupancy #(
  parameter int Depth         = 12,
  parameter int WritePorts    = 4,
  parameter int DispatchLanes = 2
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush_i,
  ibuffWrIf.count               wr,
  ibuffRdIf.count               rd,
  output logic [$clog2(Depth):0] instCount_o,
  output logic                  bufFull_o,
  output logic                  bundleAvail_o
);

  localparam int PtrWidth = $clog2(Depth);
  localparam int CntWidth = PtrWidth + 1;
  localparam logic [CntWidth-1:0] DepthCnt   = CntWidth'(Depth);
  // Above this there is no room for a whole write bundle
  localparam logic [CntWidth-1:0] FullThresh = CntWidth'(Depth - WritePorts);
  localparam logic [CntWidth-1:0] BundleCnt  = CntWidth'(DispatchLanes);

  logic [CntWidth-1:0] instCount;

  // Writes and dispatches of one cycle both land on the same edge
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      instCount <= '0;
    end
    else if (flush_i)
    begin
      instCount <= '0;
    end
    else
    begin
      instCount <= instCount + wr.acceptCount - rd.dispatchCount;
    end
  end

  assign instCount_o   = instCount;
  assign bufFull_o     = instCount > FullThresh;
  // Dispatch waits for a complete bundle
  assign bundleAvail_o = instCount >= BundleCnt;

  // Full threshold in front of the write controller keeps this bounded
  assert property (@(posedge clk) disable iff (reset) instCount <= DepthCnt)
  else $error("instruction count %0d over depth", instCount);

endmodule

// ==== ibuffDispatchCtrl.sv ====
`timescale 1ns/1ps

module ibuffDispatchCtrl #(
  parameter int Depth         = 12,
  parameter int DispatchLanes = 2
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              flush_i,
  input  logic                              stall_i,
  input  logic                              commitCsr_i,
  input  logic [ibuffPkg::StatusWidth-1:0]  csrStatus_i,
  input  logic [$clog2(Depth):0]            instCount_i,
  input  logic                              bundleAvail_i,
  output logic                              instBufferReady_o,
  output logic                              stallForCsr_o,
  output ibuffPkg::ibuffPacket              renPacket_o [DispatchLanes],
  ibuffRdIf.ctrl                            rd
);

  localparam int PtrWidth = $clog2(Depth);
  localparam int CntWidth = PtrWidth + 1;
  localparam logic [CntWidth-1:0] DepthCnt = CntWidth'(Depth);

  logic [PtrWidth-1:0]        headPtr;
  logic [CntWidth-1:0]        headNext;
  ibuffPkg::ibuffPacket       pkt [DispatchLanes];
  logic [DispatchLanes-1:0]   laneMask;
  logic                       fpDisabled;
  logic                       csrStall;
  logic                       excStall;
  logic                       csrDispatched;
  logic                       excDispatched;

  // Lane i reads head+i, wrapped
  always_comb
  begin
    logic [CntWidth-1:0] slot;
    for (int i = 0; i < DispatchLanes; i++)
    begin
      slot = {1'b0, headPtr} + CntWidth'(i);
      if (slot >= DepthCnt)
      begin
        slot = slot - DepthCnt;
      end
      rd.rdAddr[i] = slot[PtrWidth-1:0];
    end
  end

  // Status is checked here, where it is already up to date
  // since CSR writes serialize the pipe
  assign fpDisabled = ~csrStatus_i[ibuffPkg::StatusFpEnable];

  // FP work with the unit off becomes an excepting packet
  always_comb
  begin
    for (int i = 0; i < DispatchLanes; i++)
    begin
      pkt[i] = rd.rdData[i];
      if (fpDisabled && ((pkt[i].opcode == ibuffPkg::OpLoadFp) ||
                         (pkt[i].opcode == ibuffPkg::OpStoreFp) ||
                         (pkt[i].opcode == ibuffPkg::OpOpFp)))
      begin
        pkt[i].exception = 1'b1;
        pkt[i].cause     = ibuffPkg::CauseFpDisabled;
      end
    end
  end

  // Full bundle present, no back-pressure, not serializing
  assign instBufferReady_o = bundleAvail_i & ~stall_i & ~csrStall & ~excStall;
  assign stallForCsr_o     = csrStall | excStall;

  // The first CSR or excepting packet ends the bundle
  // It still goes out itself, everything after it waits
  always_comb
  begin
    laneMask[0] = instBufferReady_o & (instCount_i != '0) & pkt[0].valid;
    for (int i = 1; i < DispatchLanes; i++)
    begin
      laneMask[i] = laneMask[i-1] & ~(pkt[i-1].isCsr | pkt[i-1].exception) &
                    (instCount_i > CntWidth'(i)) & pkt[i].valid;
    end
  end

  // Only valid is squashed and the other fields pass as read
  always_comb
  begin
    rd.dispatchCount = '0;
    csrDispatched    = 1'b0;
    excDispatched    = 1'b0;
    for (int i = 0; i < DispatchLanes; i++)
    begin
      renPacket_o[i]       = pkt[i];
      renPacket_o[i].valid = laneMask[i];
      rd.dispatchCount     = rd.dispatchCount + CntWidth'(laneMask[i]);
      csrDispatched        = csrDispatched | (laneMask[i] & pkt[i].isCsr);
      excDispatched        = excDispatched | (laneMask[i] & pkt[i].exception);
    end
  end

  // Head skips exactly what left
  always_comb
  begin
    headNext = {1'b0, headPtr} + rd.dispatchCount;
    if (headNext >= DepthCnt)
    begin
      headNext = headNext - DepthCnt;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      headPtr  <= '0;
      csrStall <= 1'b0;
      excStall <= 1'b0;
    end
    else if (flush_i)
    begin
      headPtr  <= '0;
      csrStall <= 1'b0;
      excStall <= 1'b0;
    end
    else
    begin
      headPtr <= headNext[PtrWidth-1:0];
      // CSR waits for its own commit
      if (commitCsr_i)
      begin
        csrStall <= 1'b0;
      end
      else if (csrDispatched)
      begin
        csrStall <= 1'b1;
      end
      // exception only ends with the flush from the trap
      if (excDispatched)
      begin
        excStall <= 1'b1;
      end
    end
  end

  // Never hand out more than the occupancy tracker says is held
  assert property (@(posedge clk) disable iff (reset) rd.dispatchCount <= instCount_i)
  else $error("dispatching %0d with only %0d held", rd.dispatchCount, instCount_i);

endmodule

// ==== ibuffWriteCtrl.sv ====
`timescale 1ns/1ps

module ibuffWriteCtrl #(
  parameter int Depth      = 12,
  parameter int WritePorts = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush_i,
  input  logic                 decodeReady_i,
  input  logic                 bufFull_i,
  input  ibuffPkg::ibuffPacket ibPacket_i [WritePorts],
  ibuffWrIf.ctrl               wr
);

  localparam int PtrWidth = $clog2(Depth);
  localparam int CntWidth = PtrWidth + 1;
  localparam logic [CntWidth-1:0] DepthCnt = CntWidth'(Depth);

  logic [PtrWidth-1:0] tailPtr;
  logic [CntWidth-1:0] tailNext;
  logic                accept;

  // Whole bundle is taken or none of it
  // Full already leaves room for WritePorts packets
  assign accept = decodeReady_i & ~bufFull_i & ~flush_i;

  // Running sum of valid lanes gives each packet its slot
  // Invalid lanes take no slot, so the queue stays dense
  always_comb
  begin
    logic [CntWidth-1:0] offset;
    logic [CntWidth-1:0] slot;
    offset = '0;
    for (int i = 0; i < WritePorts; i++)
    begin
      slot = {1'b0, tailPtr} + offset;
      // Wrap by subtraction, Depth need not be a power of two
      if (slot >= DepthCnt)
      begin
        slot = slot - DepthCnt;
      end
      wr.wrAddr[i] = slot[PtrWidth-1:0];
      wr.wrEn[i]   = accept & ibPacket_i[i].valid;
      wr.wrData[i] = ibPacket_i[i];
      offset       = offset + CntWidth'(ibPacket_i[i].valid);
    end
    wr.acceptCount = accept ? offset : '0;
  end

  // Tail moves past every packet written
  always_comb
  begin
    tailNext = {1'b0, tailPtr} + wr.acceptCount;
    if (tailNext >= DepthCnt)
    begin
      tailNext = tailNext - DepthCnt;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      tailPtr <= '0;
    end
    else if (flush_i)
    begin
      tailPtr <= '0;
    end
    else
    begin
      tailPtr <= tailNext[PtrWidth-1:0];
    end
  end

  // Wrap logic must keep the tail inside the array
  assert property (@(posedge clk) disable iff (reset) {1'b0, tailPtr} < DepthCnt)
  else $error("tail pointer %0d outside the buffer", tailPtr);

endmodule

// ==== ibuffStorage.sv ====
`timescale 1ns/1ps

module ibuffStorage #(
  parameter int Depth         = 12,
  parameter int WritePorts    = 4,
  parameter int DispatchLanes = 2
) (
  input logic    clk,
  ibuffWrIf.mem  wr,
  ibuffRdIf.mem  rd
);

  // Entry array
  // Only the entries counted by the occupancy tracker are live
  ibuffPkg::ibuffPacket mem [Depth];

  // All write lanes land on the same edge
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < WritePorts; i++)
    begin
      if (wr.wrEn[i])
      begin
        mem[wr.wrAddr[i]] <= wr.wrData[i];
      end
    end
  end

  // Read lanes are plain muxes, no read latency
  always_comb
  begin
    for (int i = 0; i < DispatchLanes; i++)
    begin
      rd.rdData[i] = mem[rd.rdAddr[i]];
    end
  end

  // Compaction in the write controller must hand out distinct slots
  for (genvar i = 0; i < WritePorts; i++)
  begin : gWrA
    for (genvar j = i + 1; j < WritePorts; j++)
    begin : gWrB
      assert property (@(posedge clk)
        !(wr.wrEn[i] && wr.wrEn[j] && (wr.wrAddr[i] == wr.wrAddr[j])))
      else $error("write lanes %0d and %0d hit the same slot", i, j);
    end
  end

endmodule

// ==== ibuffIf.sv ====
`timescale 1ns/1ps

// Write side with one address, enable and packet per lane
interface ibuffWrIf #(
  parameter int Depth      = 12,
  parameter int WritePorts = 4
);
  localparam int PtrWidth = $clog2(Depth);
  localparam int CntWidth = PtrWidth + 1;

  logic                       wrEn        [WritePorts];
  logic [PtrWidth-1:0]        wrAddr      [WritePorts];
  ibuffPkg::ibuffPacket       wrData      [WritePorts];
  // Packets written this cycle
  logic [CntWidth-1:0]        acceptCount;

  modport ctrl  (output wrEn, output wrAddr, output wrData, output acceptCount);
  modport mem   (input wrEn, input wrAddr, input wrData);
  modport count (input acceptCount);
endinterface

// Read side with head-relative addresses out and packets back the same cycle
interface ibuffRdIf #(
  parameter int Depth         = 12,
  parameter int DispatchLanes = 2
);
  localparam int PtrWidth = $clog2(Depth);
  localparam int CntWidth = PtrWidth + 1;

  logic [PtrWidth-1:0]        rdAddr        [DispatchLanes];
  ibuffPkg::ibuffPacket       rdData        [DispatchLanes];
  // Packets leaving this cycle
  logic [CntWidth-1:0]        dispatchCount;

  modport ctrl  (output rdAddr, input rdData, output dispatchCount);
  modport mem   (input rdAddr, output rdData);
  modport count (input dispatchCount);
endinterface

// ==== ibuffPkg.sv ====
package ibuffPkg;

  // Write lanes per cycle
  // Two per fetch lane, since fission can split one fetched instruction in two
  localparam int DefaultWritePorts = 4;

  // Width of one dispatch bundle
  localparam int DefaultDispatchLanes = 2;

  // Buffer entries
  // Deliberately not a power of two, so pointers wrap explicitly
  localparam int DefaultDepth = 12;

  // Control and status register word
  localparam int StatusWidth = 32;

  // FP-enable bit in the status word
  localparam int StatusFpEnable = 4;

  // Opcodes that need the FP unit
  localparam logic [6:0] OpLoadFp  = 7'b0000111;
  localparam logic [6:0] OpStoreFp = 7'b0100111;
  localparam logic [6:0] OpOpFp    = 7'b1010011;

  // Trap cause raised when the FP unit is switched off
  localparam logic [3:0] CauseFpDisabled = 4'h7;

  // Decoded instruction as held in the buffer, 40 bits
  typedef struct packed {
    // Slot holds a real instruction
    logic        valid;
    // Major opcode, checked for FP use
    logic [6:0]  opcode;
    // Must dispatch alone and serialize the pipe
    logic        isCsr;
    logic        exception;
    logic [3:0]  cause;
    // Rest of the decoded instruction, not touched here
    logic [25:0] tag;
  } ibuffPacket;

endpackage
